/* tb.f */
source/fetch_pkg.sv
source/first_select.sv
source/fill_entry.sv
source/next_line_prefetcher.sv
source/fetch_buffer.sv
source/fetch_unit_top.sv
dv/fetch_unit_assertions.sv
dv/fetch_unit_tb.sv

/* Makefile */
TOP := fetch_unit_tb
SIM := obj_dir/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): tb.f $(wildcard source/*.sv dv/*.sv)
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

# Pass only when the testbench prints its pass line
run: $(SIM)
	@out=$$(./$(SIM) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qx 'NO ERRORS'

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* dv/fetch_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int          NUM_REQS       = 160;
    localparam int          TIMEOUT_CYCLES = NUM_REQS * 20 + 100;
    localparam logic [31:0] SEED           = 32'd30530;
    localparam addr_t       REGION_BASE    = 32'h0000_1000;
    localparam addr_t       BURST_BASE     = 32'h0000_8000;

    typedef struct {
        line_addr_t line;
        entry_id_t  id;
        int         due;
    } fill_rec_t;

    logic               clk = 1'b0;
    logic               arst_n;
    logic               fe_req_valid;
    addr_t              fe_req_addr;
    tag_t               fe_req_tag;
    logic               fb_full;
    logic               fe_rsp_valid;
    logic [INSTR_W-1:0] fe_rsp_instr;
    addr_t              fe_rsp_pc;
    tag_t               fe_rsp_tag;
    logic               ic_req_valid;
    line_addr_t         ic_req_line;
    entry_id_t          ic_req_id;
    logic               ic_rsp_valid;
    entry_id_t          ic_rsp_id;
    line_data_t         ic_rsp_data;

    // Scoreboard, line array model and cache model
    addr_t               exp_pc [tag_t];
    logic                allowed_line [line_addr_t];
    fill_rec_t           fill_q [$];
    logic [NUM_SETS-1:0] model_valid = '0;
    line_addr_t          model_line [NUM_SETS];
    logic                nxt_valid = 1'b0;
    entry_id_t           nxt_id = '0;
    line_addr_t          nxt_line = '0;
    logic [31:0]         lat_rng = SEED;
    logic                seen_req = 1'b0;
    logic                hit_due = 1'b0;
    tag_t                hit_tag = '0;
    logic                full_check_due = 1'b0;
    int                  cyc = 0;
    int                  errors = 0;
    int                  req_count = 0;
    int                  rsp_count = 0;

    fetch_unit_top dut_i (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Instruction stored at a byte address
    function automatic logic [INSTR_W-1:0] word_of(input addr_t addr);
        return {addr[15:0], addr[31:16]} ^ (addr << 5) ^ 32'h9E37_79B9;
    endfunction

    function automatic line_data_t line_fill_data(input line_addr_t line);
        line_data_t data;
        for (int w = 0; w < LINE_WORDS; w++) begin
            data[w*INSTR_W +: INSTR_W] = word_of({line, w[1:0], 2'b00});
        end
        return data;
    endfunction

    function automatic bit find_free_tag(output tag_t tag);
        bit found;
        found = 1'b0;
        tag = '0;
        for (int t = (1 << TAG_W) - 1; t >= 0; t--) begin
            if (!exp_pc.exists(tag_t'(t))) begin
                tag = tag_t'(t);
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic check_quiet_start();
        assert (!fe_rsp_valid) else begin
            $display("error t=%0t fe_rsp_valid expected 0 got %b", $time, fe_rsp_valid);
            errors++;
        end
        assert (!ic_req_valid) else begin
            $display("error t=%0t ic_req_valid expected 0 got %b", $time, ic_req_valid);
            errors++;
        end
        assert (!fb_full) else begin
            $display("error t=%0t fb_full expected 0 got %b", $time, fb_full);
            errors++;
        end
    endtask

    task automatic check_hit_timing();
        assert (fe_rsp_valid) else begin
            $display("error t=%0t fe_rsp_valid expected 1 got %b after hit on tag %0h",
                     $time, fe_rsp_valid, hit_tag);
            errors++;
        end
        if (fe_rsp_valid) begin
            assert (fe_rsp_tag == hit_tag) else begin
                $display("error t=%0t fe_rsp_tag expected %0h got %0h",
                         $time, hit_tag, fe_rsp_tag);
                errors++;
            end
        end
    endtask

    task automatic check_response();
        rsp_count++;
        assert (exp_pc.exists(fe_rsp_tag)) else begin
            $display("response at %0t has tag %0h with no request open", $time, fe_rsp_tag);
            errors++;
        end
        if (exp_pc.exists(fe_rsp_tag)) begin
            assert (fe_rsp_pc == exp_pc[fe_rsp_tag]) else begin
                $display("error t=%0t fe_rsp_pc expected %h got %h",
                         $time, exp_pc[fe_rsp_tag], fe_rsp_pc);
                errors++;
            end
            assert (fe_rsp_instr == word_of(exp_pc[fe_rsp_tag])) else begin
                $display("error t=%0t fe_rsp_instr expected %h got %h",
                         $time, word_of(exp_pc[fe_rsp_tag]), fe_rsp_instr);
                errors++;
            end
            exp_pc.delete(fe_rsp_tag);
        end
    endtask

    // The cycle after the opening burst of misses
    task automatic check_full_after_burst();
        assert (fb_full) else begin
            $display("error t=%0t fb_full expected 1 got %b", $time, fb_full);
            errors++;
        end
        assert (exp_pc.num() == NUM_ENTRIES) else begin
            $display("buffer full with %0d demand misses open instead of four", exp_pc.num());
            errors++;
        end
    endtask

    task automatic record_cache_request();
        fill_rec_t rec;
        assert (allowed_line.exists(ic_req_line)) else begin
            $display("cache request at %0t for line %h that no demand request led to",
                     $time, ic_req_line);
            errors++;
        end
        lat_rng = lcg_next(lat_rng);
        rec.line = ic_req_line;
        rec.id   = ic_req_id;
        rec.due  = cyc + 2 + int'(lat_rng[18:16]);
        fill_q.push_back(rec);
    endtask

    task automatic record_request();
        line_addr_t rl;
        set_idx_t   rs;
        rl = fe_req_addr[ADDR_W-1:4];
        rs = rl[SET_W-1:0];
        seen_req = 1'b1;
        req_count++;
        full_check_due = (req_count == NUM_ENTRIES);
        assert (!exp_pc.exists(fe_req_tag)) else begin
            $display("tag %0h reused at %0t while still open", fe_req_tag, $time);
            errors++;
        end
        exp_pc[fe_req_tag] = fe_req_addr;
        hit_due = model_valid[rs] && (model_line[rs] == rl);
        hit_tag = fe_req_tag;
        if (!hit_due) begin
            allowed_line[rl] = 1'b1;
        end
        allowed_line[rl + line_addr_t'(1)] = 1'b1;
    endtask

    // Pick any due fill so fills return out of order
    task automatic schedule_fill();
        bit found;
        found = 1'b0;
        nxt_valid = 1'b0;
        for (int i = 0; i < fill_q.size(); i++) begin
            if (!found && (fill_q[i].due <= cyc + 1)) begin
                found     = 1'b1;
                nxt_valid = 1'b1;
                nxt_id    = fill_q[i].id;
                nxt_line  = fill_q[i].line;
                fill_q.delete(i);
            end
        end
    endtask

    always @(posedge clk) begin
        if (arst_n) begin
            if (!seen_req) begin
                check_quiet_start();
            end
            if (hit_due) begin
                check_hit_timing();
            end
            if (fe_rsp_valid) begin
                check_response();
            end
            if (full_check_due) begin
                check_full_after_burst();
                full_check_due = 1'b0;
            end
            if (ic_req_valid) begin
                record_cache_request();
            end
            hit_due = 1'b0;
            if (fe_req_valid) begin
                record_request();
            end
            // Fill lands in the array after this cycle's lookup
            if (ic_rsp_valid) begin
                model_valid[nxt_line[SET_W-1:0]] = 1'b1;
                model_line[nxt_line[SET_W-1:0]]  = nxt_line;
            end
            schedule_fill();
        end
        cyc++;
    end

    // Cache fill driver
    initial begin
        ic_rsp_valid = 1'b0;
        ic_rsp_id    = '0;
        ic_rsp_data  = '0;
        forever begin
            @(negedge clk);
            ic_rsp_valid = nxt_valid;
            ic_rsp_id    = nxt_id;
            ic_rsp_data  = line_fill_data(nxt_line);
        end
    end

    initial begin
        tag_t        tag;
        int          gap;
        int          end_errors;
        int          total;
        logic [31:0] stim_rng;
        end_errors   = 0;
        stim_rng     = SEED;
        arst_n       = 1'b0;
        fe_req_valid = 1'b0;
        fe_req_addr  = '0;
        fe_req_tag   = '0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        repeat (3) @(negedge clk);
        // Four quick misses on distinct lines
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            fe_req_valid = 1'b1;
            fe_req_addr  = BURST_BASE + addr_t'(i * 64);
            fe_req_tag   = tag_t'(i);
            @(negedge clk);
        end
        for (int n = NUM_ENTRIES; n < NUM_REQS; n++) begin
            fe_req_valid = 1'b0;
            stim_rng = lcg_next(stim_rng);
            gap = int'(stim_rng[17:16]);
            repeat (gap) @(negedge clk);
            while (fb_full || !find_free_tag(tag)) begin
                @(negedge clk);
            end
            stim_rng = lcg_next(stim_rng);
            fe_req_addr  = REGION_BASE + addr_t'(stim_rng[21:16]) * 4;
            fe_req_tag   = tag;
            fe_req_valid = 1'b1;
            @(negedge clk);
        end
        fe_req_valid = 1'b0;
        while (exp_pc.num() != 0) begin
            @(negedge clk);
        end
        // Catch late extra responses
        repeat (20) @(negedge clk);
        assert (rsp_count == req_count) else begin
            $display("%0d requests got %0d responses", req_count, rsp_count);
            end_errors++;
        end
        total = errors + end_errors + dut_i.buffer_i.asserts_i.req_when_full_fails +
                dut_i.buffer_i.asserts_i.bad_id_fails +
                dut_i.buffer_i.asserts_i.unknown_rsp_fails;
        $display("requests %0d, responses %0d, errors %0d", req_count, rsp_count, total);
        if (total == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (cyc >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles with %0d requests still open", cyc, exp_pc.num());
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/fetch_unit_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit_assertions (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                fe_req_valid,
    input  logic                                fb_full,
    input  logic                                fe_rsp_valid,
    input  logic                                ic_req_valid,
    input  fetch_pkg::entry_id_t                ic_req_id,
    input  logic [fetch_pkg::NUM_ENTRIES-1:0]   entry_ic_req
);

    import fetch_pkg::*;

    int req_when_full_fails = 0;
    int bad_id_fails        = 0;
    int unknown_rsp_fails   = 0;

    // Front end holds off while every entry is busy
    no_req_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) fb_full |-> !fe_req_valid
    ) else begin
        $error("front end request while the fetch buffer is full");
        req_when_full_fails++;
    end

    // The id on the bus names an entry that is asking for the bus
    id_is_requester: assert property (
        @(posedge clk) disable iff (!arst_n) ic_req_valid |-> entry_ic_req[ic_req_id]
    ) else begin
        $error("cache request carries the id of an entry that is not requesting");
        bad_id_fails++;
    end

    rsp_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(fe_rsp_valid)
    ) else begin
        $error("response valid is unknown");
        unknown_rsp_fails++;
    end

endmodule

bind fetch_buffer fetch_unit_assertions asserts_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .fe_req_valid (fe_req_valid),
    .fb_full      (fb_full),
    .fe_rsp_valid (fe_rsp_valid),
    .ic_req_valid (ic_req_valid),
    .ic_req_id    (ic_req_id),
    .entry_ic_req (entry_ic_req)
);

`default_nettype wire

/* source/fetch_unit_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    fe_req_valid,
    input  fetch_pkg::addr_t        fe_req_addr,
    input  fetch_pkg::tag_t         fe_req_tag,
    output logic                    fb_full,
    output logic                    fe_rsp_valid,
    output logic [fetch_pkg::INSTR_W-1:0] fe_rsp_instr,
    output fetch_pkg::addr_t        fe_rsp_pc,
    output fetch_pkg::tag_t         fe_rsp_tag,
    output logic                    ic_req_valid,
    output fetch_pkg::line_addr_t   ic_req_line,
    output fetch_pkg::entry_id_t    ic_req_id,
    input  logic                    ic_rsp_valid,
    input  fetch_pkg::entry_id_t    ic_rsp_id,
    input  fetch_pkg::line_data_t   ic_rsp_data
);

    import fetch_pkg::*;

    // Prefetch candidate handshake
    logic       pf_req_valid;
    line_addr_t pf_req_line;
    logic       pf_grant;

    fetch_buffer buffer_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .fe_req_valid (fe_req_valid),
        .fe_req_addr  (fe_req_addr),
        .fe_req_tag   (fe_req_tag),
        .fb_full      (fb_full),
        .fe_rsp_valid (fe_rsp_valid),
        .fe_rsp_instr (fe_rsp_instr),
        .fe_rsp_pc    (fe_rsp_pc),
        .fe_rsp_tag   (fe_rsp_tag),
        .ic_req_valid (ic_req_valid),
        .ic_req_line  (ic_req_line),
        .ic_req_id    (ic_req_id),
        .ic_rsp_valid (ic_rsp_valid),
        .ic_rsp_id    (ic_rsp_id),
        .ic_rsp_data  (ic_rsp_data),
        .pf_req_valid (pf_req_valid),
        .pf_req_line  (pf_req_line),
        .pf_grant     (pf_grant)
    );

    next_line_prefetcher prefetcher_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .fe_req_valid (fe_req_valid),
        .fe_req_addr  (fe_req_addr),
        .pf_req_valid (pf_req_valid),
        .pf_req_line  (pf_req_line),
        .pf_grant     (pf_grant)
    );

endmodule

`default_nettype wire

/* source/fetch_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_buffer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    fe_req_valid,
    input  fetch_pkg::addr_t        fe_req_addr,
    input  fetch_pkg::tag_t         fe_req_tag,
    output logic                    fb_full,
    output logic                    fe_rsp_valid,
    output logic [fetch_pkg::INSTR_W-1:0] fe_rsp_instr,
    output fetch_pkg::addr_t        fe_rsp_pc,
    output fetch_pkg::tag_t         fe_rsp_tag,
    output logic                    ic_req_valid,
    output fetch_pkg::line_addr_t   ic_req_line,
    output fetch_pkg::entry_id_t    ic_req_id,
    input  logic                    ic_rsp_valid,
    input  fetch_pkg::entry_id_t    ic_rsp_id,
    input  fetch_pkg::line_data_t   ic_rsp_data,
    input  logic                    pf_req_valid,
    input  fetch_pkg::line_addr_t   pf_req_line,
    output logic                    pf_grant
);

    import fetch_pkg::*;

    // Line array
    logic [NUM_SETS-1:0] arr_valid;
    line_addr_t          arr_line [NUM_SETS];
    line_data_t          arr_data [NUM_SETS];

    line_addr_t req_line;
    set_idx_t   req_set;
    word_sel_t  req_word;
    logic       hit;
    logic       demand_miss;

    logic       pf_pending;
    logic       pf_cached;
    logic       pf_alloc;

    logic [NUM_ENTRIES-1:0] entry_valid;
    logic [NUM_ENTRIES-1:0] alloc_sel;
    logic [NUM_ENTRIES-1:0] entry_push;
    logic [NUM_ENTRIES-1:0] entry_ic_req;
    logic [NUM_ENTRIES-1:0] entry_rsp_req;
    logic [NUM_ENTRIES-1:0] entry_fill;
    line_addr_t             entry_line [NUM_ENTRIES];
    fe_rsp_t                entry_rsp [NUM_ENTRIES];

    logic [NUM_ENTRIES-1:0] ic_gnt;
    logic [NUM_ENTRIES-1:0] rsp_gnt;
    logic                   rsp_any;
    fe_rsp_t                rsp_sel;
    fe_rsp_t                hit_rsp;

    line_addr_t fill_line;
    set_idx_t   fill_set;

    // Hit detection keeps the full line address as the tag
    assign req_line    = line_of(fe_req_addr);
    assign req_set     = set_of(req_line);
    assign req_word    = word_sel_of(fe_req_addr);
    assign hit         = fe_req_valid && arr_valid[req_set] && (arr_line[req_set] == req_line);
    assign demand_miss = fe_req_valid && !hit;

    always_comb begin
        hit_rsp.instr = arr_data[req_set][req_word*INSTR_W +: INSTR_W];
        hit_rsp.pc    = fe_req_addr;
        hit_rsp.tag   = fe_req_tag;
    end

    // Drop a prefetch whose line is already in flight or present
    always_comb begin
        pf_pending = 1'b0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (entry_valid[i] && (entry_line[i] == pf_req_line)) begin
                pf_pending = 1'b1;
            end
        end
    end

    assign pf_cached = arr_valid[set_of(pf_req_line)] &&
                       (arr_line[set_of(pf_req_line)] == pf_req_line);

    assign fb_full  = &entry_valid;
    assign pf_alloc = pf_req_valid && !demand_miss && !fb_full && !pf_pending && !pf_cached;
    assign pf_grant = pf_req_valid && !demand_miss && (!fb_full || pf_pending || pf_cached);

    // First free entry
    always_comb begin
        alloc_sel = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (!entry_valid[i] && (alloc_sel == '0)) begin
                alloc_sel[i] = 1'b1;
            end
        end
    end

    assign entry_push = alloc_sel & {NUM_ENTRIES{demand_miss || pf_alloc}};

    for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_entry
        assign entry_fill[i] = ic_rsp_valid && (ic_rsp_id == entry_id_t'(i));

        fill_entry entry_i (
            .clk         (clk),
            .arst_n      (arst_n),
            .push        (entry_push[i]),
            .push_line   (demand_miss ? req_line : pf_req_line),
            .push_tag    (demand_miss ? fe_req_tag : tag_t'(0)),
            .push_offset (demand_miss ? req_word : word_sel_t'(0)),
            .push_is_pf  (!demand_miss),
            .valid       (entry_valid[i]),
            .line        (entry_line[i]),
            .ic_req      (entry_ic_req[i]),
            .ic_grant    (ic_gnt[i]),
            .fill_valid  (entry_fill[i]),
            .fill_data   (ic_rsp_data),
            .rsp_req     (entry_rsp_req[i]),
            .rsp_payload (entry_rsp[i]),
            .rsp_grant   (rsp_gnt[i] && !hit)
        );
    end

    first_select #(
        .N         (NUM_ENTRIES),
        .payload_t (line_addr_t)
    ) ic_select_i (
        .req         (entry_ic_req),
        .payload     (entry_line),
        .grant       (ic_gnt),
        .any         (ic_req_valid),
        .sel_payload (ic_req_line)
    );

    always_comb begin
        ic_req_id = '0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            if (ic_gnt[i]) begin
                ic_req_id = entry_id_t'(i);
            end
        end
    end

    first_select #(
        .N         (NUM_ENTRIES),
        .payload_t (fe_rsp_t)
    ) rsp_select_i (
        .req         (entry_rsp_req),
        .payload     (entry_rsp),
        .grant       (rsp_gnt),
        .any         (rsp_any),
        .sel_payload (rsp_sel)
    );

    // Every prefetch or demand fill lands in the array
    assign fill_line = entry_line[ic_rsp_id];
    assign fill_set  = set_of(fill_line);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arr_valid <= '0;
        end else if (ic_rsp_valid) begin
            arr_valid[fill_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ic_rsp_valid) begin
            arr_line[fill_set] <= fill_line;
            arr_data[fill_set] <= ic_rsp_data;
        end
    end

    // A hit takes the registered response path ahead of any entry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fe_rsp_valid <= 1'b0;
        end else begin
            fe_rsp_valid <= hit || rsp_any;
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            fe_rsp_instr <= hit_rsp.instr;
            fe_rsp_pc    <= hit_rsp.pc;
            fe_rsp_tag   <= hit_rsp.tag;
        end else if (rsp_any) begin
            fe_rsp_instr <= rsp_sel.instr;
            fe_rsp_pc    <= rsp_sel.pc;
            fe_rsp_tag   <= rsp_sel.tag;
        end
    end

endmodule

`default_nettype wire

/* source/next_line_prefetcher.sv */
`timescale 1ns/1ns
`default_nettype none

module next_line_prefetcher (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  fe_req_valid,
    input  fetch_pkg::addr_t      fe_req_addr,
    output logic                  pf_req_valid,
    output fetch_pkg::line_addr_t pf_req_line,
    input  logic                  pf_grant
);

    import fetch_pkg::*;

    line_addr_t next_line;

    // Sequential fetch guesses the line just ahead
    assign next_line = line_of(fe_req_addr) + 1'b1;

    // A newer demand request replaces the candidate, even in a grant cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pf_req_valid <= 1'b0;
        end else if (fe_req_valid) begin
            pf_req_valid <= 1'b1;
        end else if (pf_grant) begin
            pf_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fe_req_valid) begin
            pf_req_line <= next_line;
        end
    end

endmodule

`default_nettype wire

/* source/fill_entry.sv */
`timescale 1ns/1ns
`default_nettype none

module fill_entry (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 push,
    input  fetch_pkg::line_addr_t push_line,
    input  fetch_pkg::tag_t      push_tag,
    input  fetch_pkg::word_sel_t push_offset,
    input  logic                 push_is_pf,
    output logic                 valid,
    output fetch_pkg::line_addr_t line,
    output logic                 ic_req,
    input  logic                 ic_grant,
    input  logic                 fill_valid,
    input  fetch_pkg::line_data_t fill_data,
    output logic                 rsp_req,
    output fetch_pkg::fe_rsp_t   rsp_payload,
    input  logic                 rsp_grant
);

    import fetch_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_RSP
    } state_t;

    state_t state;

    tag_t               tag;
    word_sel_t          offset;
    logic               is_pf;
    logic [INSTR_W-1:0] instr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (push) state <= S_REQ;
                S_REQ: if (ic_grant) state <= S_WAIT;
                // Prefetch fills only warm the array and return nothing
                S_WAIT: if (fill_valid) state <= is_pf ? S_IDLE : S_RSP;
                S_RSP: if (rsp_grant) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && (state == S_IDLE)) begin
            line   <= push_line;
            tag    <= push_tag;
            offset <= push_offset;
            is_pf  <= push_is_pf;
        end
        // Keep only the word the front end asked for
        if (fill_valid && (state == S_WAIT)) begin
            instr <= fill_data[offset*INSTR_W +: INSTR_W];
        end
    end

    assign valid   = (state != S_IDLE);
    assign ic_req  = (state == S_REQ);
    assign rsp_req = (state == S_RSP);

    always_comb begin
        rsp_payload.instr = instr;
        rsp_payload.pc    = {line, offset, 2'b00};
        rsp_payload.tag   = tag;
    end

endmodule

`default_nettype wire

/* source/first_select.sv */
`timescale 1ns/1ns
`default_nettype none

module first_select #(
    parameter int  N         = 4,
    parameter type payload_t = logic
) (
    input  logic [N-1:0] req,
    input  payload_t     payload [N],
    output logic [N-1:0] grant,
    output logic         any,
    output payload_t     sel_payload
);

    // Lowest index wins
    always_comb begin
        grant = '0;
        for (int i = 0; i < N; i++) begin
            if (req[i] && (grant == '0)) begin
                grant[i] = 1'b1;
            end
        end
    end

    assign any = |req;

    // Payload follows the one-hot grant
    always_comb begin
        sel_payload = payload[0];
        for (int i = 0; i < N; i++) begin
            if (grant[i]) begin
                sel_payload = payload[i];
            end
        end
    end

endmodule

`default_nettype wire

/* source/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    localparam int ADDR_W      = 32;
    localparam int INSTR_W     = 32;
    localparam int LINE_WORDS  = 4;
    localparam int LINE_W      = LINE_WORDS * INSTR_W;
    localparam int OFFSET_W    = 4;
    localparam int WORD_SEL_W  = 2;
    localparam int NUM_SETS    = 8;
    localparam int SET_W       = 3;
    localparam int NUM_ENTRIES = 4;
    localparam int ENTRY_IDX_W = 2;
    localparam int TAG_W       = 4;

    typedef logic [ADDR_W-1:0]          addr_t;
    typedef logic [ADDR_W-OFFSET_W-1:0] line_addr_t;
    typedef logic [LINE_W-1:0]          line_data_t;
    typedef logic [SET_W-1:0]           set_idx_t;
    typedef logic [WORD_SEL_W-1:0]      word_sel_t;
    typedef logic [ENTRY_IDX_W-1:0]     entry_id_t;
    typedef logic [TAG_W-1:0]           tag_t;

    // Front end response payload of 68 bits
    typedef struct packed {
        logic [INSTR_W-1:0] instr;
        addr_t              pc;
        tag_t               tag;
    } fe_rsp_t;

    function automatic line_addr_t line_of(addr_t addr);
        return addr[ADDR_W-1:OFFSET_W];
    endfunction

    // Low line bits pick the set of the direct mapped array
    function automatic set_idx_t set_of(line_addr_t line);
        return line[SET_W-1:0];
    endfunction

    function automatic word_sel_t word_sel_of(addr_t addr);
        return addr[OFFSET_W-1:OFFSET_W-WORD_SEL_W];
    endfunction

endpackage

`default_nettype wire
